// File: include/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// bus widths
`define DC_ADDR_W 32
`define DC_DATA_W 32
`define DC_SEL_W 4

// cache geometry, one word per line
`define DC_INDEX_W 6
`define DC_OFFSET_W 2
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

// top three address bits of the mapped kernel windows
`define DC_KSEG0_TOP 3'b100
`define DC_KSEG1_TOP 3'b101

`endif

// File: src/bus_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package bus_pkg;

    // direction of one access
    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } access_op_e;

    // virtual or physical address
    typedef logic [`DC_ADDR_W-1:0] addr_t;

    typedef logic [`DC_DATA_W-1:0] data_t;

    // one bit per byte lane
    typedef logic [`DC_SEL_W-1:0] sel_t;

endpackage

`default_nettype wire

// File: src/cache_pkg.sv
`default_nettype none

`include "dcache_config.svh"

package cache_pkg;

    typedef logic [`DC_INDEX_W-1:0] index_t;

    typedef logic [`DC_TAG_W-1:0] tag_t;

    // one cache line holds a single word
    typedef struct packed {
        logic                  valid;
        tag_t                  tag;
        logic [`DC_DATA_W-1:0] data;
    } line_t;

    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        EXT_WAIT,
        DONE
    } ctrl_state_e;

endpackage

`default_nettype wire

// File: src/dcache_if.sv
`timescale 1ns/1ps
`default_nettype none

// request from the cpu port into the cache controller
interface access_if
    import bus_pkg::*;
();

    logic       req;
    access_op_e op;
    logic       uncached;
    addr_t      paddr;
    sel_t       sel;
    data_t      wdata;
    data_t      rdata;
    logic       done;

    modport initiator (
        output req, op, uncached, paddr, sel, wdata,
        input  rdata, done
    );

    modport target (
        input  req, op, uncached, paddr, sel, wdata,
        output rdata, done
    );

endinterface

// single word external cycle request
interface ext_if
    import bus_pkg::*;
();

    logic       req;
    access_op_e op;
    addr_t      addr;
    sel_t       sel;
    data_t      wdata;
    data_t      rdata;
    logic       done;

    modport initiator (
        output req, op, addr, sel, wdata,
        input  rdata, done
    );

    modport target (
        input  req, op, addr, sel, wdata,
        output rdata, done
    );

endinterface

`default_nettype wire

// File: src/cpu_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module cpu_port
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_cyc_i,
    input  logic  cpu_stb_i,
    input  logic  cpu_we_i,
    input  addr_t cpu_adr_i,
    input  sel_t  cpu_sel_i,
    input  data_t cpu_dat_i,
    output data_t cpu_dat_o,
    output logic  cpu_ack_o,
    access_if.initiator acc
);

    logic       req_q;
    logic       ack_q;
    access_op_e op_q;
    logic       uncached_q;
    addr_t      paddr_q;
    sel_t       sel_q;
    data_t      wdata_q;
    data_t      rdata_q;
    logic [2:0] seg;
    logic       start;
    logic       unc_map;
    addr_t      paddr_map;

    assign seg     = cpu_adr_i[`DC_ADDR_W-1 -: 3];
    // ack cycle still has stb high, so wait for it to pass
    assign start   = cpu_cyc_i && cpu_stb_i && !req_q && !ack_q;
    assign unc_map = (seg == `DC_KSEG1_TOP);

    // kernel windows drop the segment bits, useg is untranslated
    always_comb begin
        paddr_map = cpu_adr_i;
        if (seg == `DC_KSEG0_TOP || seg == `DC_KSEG1_TOP) begin
            paddr_map[`DC_ADDR_W-1 -: 3] = 3'b000;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            ack_q <= acc.done;
            if (start) begin
                req_q <= 1'b1;
            end else if (acc.done) begin
                req_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            op_q       <= cpu_we_i ? OP_WRITE : OP_READ;
            uncached_q <= unc_map;
            paddr_q    <= paddr_map;
            sel_q      <= cpu_sel_i;
            wdata_q    <= cpu_dat_i;
        end
        if (acc.done) begin
            rdata_q <= acc.rdata;
        end
    end

    assign acc.req      = req_q;
    assign acc.op       = op_q;
    assign acc.uncached = uncached_q;
    assign acc.paddr    = paddr_q;
    assign acc.sel      = sel_q;
    assign acc.wdata    = wdata_q;

    assign cpu_ack_o = ack_q;
    assign cpu_dat_o = rdata_q;

endmodule

`default_nettype wire

// File: src/cache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "dcache_config.svh"

module cache_ctrl
    import bus_pkg::*;
    import cache_pkg::*;
(
    input  logic clk,
    input  logic rst,
    access_if.target acc,
    ext_if.initiator ext
);

    line_t       lines [0:(1 << `DC_INDEX_W)-1];
    ctrl_state_e state_q;
    logic        ext_req_q;
    data_t       rdata_q;
    index_t      req_idx;
    tag_t        req_tag;
    line_t       cur_line;
    logic        hit;
    logic        is_read;
    data_t       merged;
    logic        line_we;
    line_t       line_wdata;

    assign req_idx  = acc.paddr[`DC_OFFSET_W +: `DC_INDEX_W];
    assign req_tag  = acc.paddr[`DC_ADDR_W-1 -: `DC_TAG_W];
    assign cur_line = lines[req_idx];
    assign hit      = cur_line.valid && (cur_line.tag == req_tag);
    assign is_read  = (acc.op == OP_READ);

    // store data merged into the cached word under the byte selects
    always_comb begin
        merged = cur_line.data;
        for (int b = 0; b < `DC_SEL_W; b++) begin
            if (acc.sel[b]) begin
                merged[b*8 +: 8] = acc.wdata[b*8 +: 8];
            end
        end
    end

    // write hit updates in place, read miss fills, nothing allocates on a write
    always_comb begin
        line_we    = 1'b0;
        line_wdata = '{valid: 1'b1, tag: req_tag, data: merged};
        if (state_q == LOOKUP && !is_read && hit) begin
            line_we = 1'b1;
        end else if (state_q == EXT_WAIT && ext.done && is_read && !acc.uncached) begin
            line_we         = 1'b1;
            line_wdata.data = ext.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `DC_INDEX_W); i++) begin
                lines[i].valid <= 1'b0;
            end
        end else if (line_we) begin
            lines[req_idx] <= line_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= IDLE;
            ext_req_q <= 1'b0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (acc.req) begin
                        // uncached goes straight to the bus
                        if (acc.uncached) begin
                            ext_req_q <= 1'b1;
                            state_q   <= EXT_WAIT;
                        end else begin
                            state_q <= LOOKUP;
                        end
                    end
                end
                LOOKUP: begin
                    if (is_read && hit) begin
                        state_q <= DONE;
                    end else begin
                        ext_req_q <= 1'b1;
                        state_q   <= EXT_WAIT;
                    end
                end
                EXT_WAIT: begin
                    if (ext.done) begin
                        ext_req_q <= 1'b0;
                        state_q   <= DONE;
                    end
                end
                DONE: begin
                    state_q <= IDLE;
                end
                default: begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    // return data picked from the array on a hit, else from the bus
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP && hit) begin
            rdata_q <= cur_line.data;
        end else if (state_q == EXT_WAIT && ext.done) begin
            rdata_q <= ext.rdata;
        end
    end

    assign acc.done  = (state_q == DONE);
    assign acc.rdata = rdata_q;

    assign ext.req   = ext_req_q;
    assign ext.op    = acc.op;
    assign ext.addr  = acc.paddr;
    // a fill needs the whole word
    assign ext.sel   = (is_read && !acc.uncached) ? '1 : acc.sel;
    assign ext.wdata = acc.wdata;

endmodule

`default_nettype wire

// File: src/bus_master.sv
`timescale 1ns/1ps
`default_nettype none

module bus_master
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    ext_if.target ext,
    output logic  mem_cyc_o,
    output logic  mem_stb_o,
    output logic  mem_we_o,
    output addr_t mem_adr_o,
    output sel_t  mem_sel_o,
    output data_t mem_dat_o,
    input  data_t mem_dat_i,
    input  logic  mem_ack_i
);

    logic  cyc_q;
    logic  done_q;
    logic  we_q;
    addr_t adr_q;
    sel_t  sel_q;
    data_t dat_q;
    data_t rdata_q;
    logic  start;
    logic  ack_seen;

    // req is still high during the done cycle
    assign start    = ext.req && !cyc_q && !done_q;
    assign ack_seen = cyc_q && mem_ack_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            cyc_q  <= 1'b0;
            done_q <= 1'b0;
        end else begin
            done_q <= ack_seen;
            if (start) begin
                cyc_q <= 1'b1;
            end else if (ack_seen) begin
                cyc_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            we_q  <= (ext.op == OP_WRITE);
            adr_q <= ext.addr;
            sel_q <= ext.sel;
            dat_q <= ext.wdata;
        end
        if (ack_seen) begin
            rdata_q <= mem_dat_i;
        end
    end

    assign mem_cyc_o = cyc_q;
    assign mem_stb_o = cyc_q;
    assign mem_we_o  = we_q;
    assign mem_adr_o = adr_q;
    assign mem_sel_o = sel_q;
    assign mem_dat_o = dat_q;

    assign ext.done  = done_q;
    assign ext.rdata = rdata_q;

endmodule

`default_nettype wire

// File: src/dcache_top.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_top
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst,

    // processor side, wishbone slave
    input  logic  cpu_cyc_i,
    input  logic  cpu_stb_i,
    input  logic  cpu_we_i,
    input  addr_t cpu_adr_i,
    input  sel_t  cpu_sel_i,
    input  data_t cpu_dat_i,
    output data_t cpu_dat_o,
    output logic  cpu_ack_o,

    // memory side, wishbone master
    output logic  mem_cyc_o,
    output logic  mem_stb_o,
    output logic  mem_we_o,
    output addr_t mem_adr_o,
    output sel_t  mem_sel_o,
    output data_t mem_dat_o,
    input  data_t mem_dat_i,
    input  logic  mem_ack_i
);

    access_if i_acc ();
    ext_if    i_ext ();

    cpu_port i_cpu_port (
        .clk       (clk),
        .rst       (rst),
        .cpu_cyc_i (cpu_cyc_i),
        .cpu_stb_i (cpu_stb_i),
        .cpu_we_i  (cpu_we_i),
        .cpu_adr_i (cpu_adr_i),
        .cpu_sel_i (cpu_sel_i),
        .cpu_dat_i (cpu_dat_i),
        .cpu_dat_o (cpu_dat_o),
        .cpu_ack_o (cpu_ack_o),
        .acc       (i_acc)
    );

    cache_ctrl i_cache_ctrl (
        .clk (clk),
        .rst (rst),
        .acc (i_acc),
        .ext (i_ext)
    );

    bus_master i_bus_master (
        .clk       (clk),
        .rst       (rst),
        .ext       (i_ext),
        .mem_cyc_o (mem_cyc_o),
        .mem_stb_o (mem_stb_o),
        .mem_we_o  (mem_we_o),
        .mem_adr_o (mem_adr_o),
        .mem_sel_o (mem_sel_o),
        .mem_dat_o (mem_dat_o),
        .mem_dat_i (mem_dat_i),
        .mem_ack_i (mem_ack_i)
    );

endmodule

`default_nettype wire

// File: verif/tb_dcache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_dcache
    import bus_pkg::*;
();

    localparam int ack_timeout = 64;

    logic  clk;
    logic  rst;
    logic  cpu_cyc;
    logic  cpu_stb;
    logic  cpu_we;
    addr_t cpu_adr;
    sel_t  cpu_sel;
    data_t cpu_wdat;
    data_t cpu_rdat;
    logic  cpu_ack;
    logic  mem_cyc;
    logic  mem_stb;
    logic  mem_we;
    addr_t mem_adr;
    sel_t  mem_sel;
    data_t mem_wdat;
    data_t mem_rdat;
    logic  mem_ack;

    // word addressed memory model state
    data_t       mem_words [logic [29:0]];
    int          ext_count;
    addr_t       last_adr;
    logic        last_we;
    sel_t        last_sel;
    data_t       last_dat;
    logic [16:0] lfsr_state = 17'd74207;

    int   errors;
    int   passed;
    int   accesses;
    logic aborted;

    dcache_top i_dcache_top (
        .clk       (clk),
        .rst       (rst),
        .cpu_cyc_i (cpu_cyc),
        .cpu_stb_i (cpu_stb),
        .cpu_we_i  (cpu_we),
        .cpu_adr_i (cpu_adr),
        .cpu_sel_i (cpu_sel),
        .cpu_dat_i (cpu_wdat),
        .cpu_dat_o (cpu_rdat),
        .cpu_ack_o (cpu_ack),
        .mem_cyc_o (mem_cyc),
        .mem_stb_o (mem_stb),
        .mem_we_o  (mem_we),
        .mem_adr_o (mem_adr),
        .mem_sel_o (mem_sel),
        .mem_dat_o (mem_wdat),
        .mem_dat_i (mem_rdat),
        .mem_ack_i (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // fibonacci lfsr on x^17 + x^14 + 1
    function automatic int draw_bits(input int count);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr_state[16]);
            fb = lfsr_state[16] ^ lfsr_state[13];
            lfsr_state = {lfsr_state[15:0], fb};
        end
        return value;
    endfunction

    // kseg0 and kseg1 lose the segment bits
    function automatic addr_t map_addr(input addr_t va);
        addr_t pa;
        pa = va;
        if (va[31:29] == 3'b100 || va[31:29] == 3'b101) begin
            pa[31:29] = 3'b000;
        end
        return pa;
    endfunction

    task automatic compare_word(input string sig, input data_t expected, input data_t actual);
        assert (actual === expected) else begin
            $display("MISMATCH at %0t: %s expected %h got %h", $time, sig, expected, actual);
            errors++;
        end
    endtask

    // wishbone slave memory with 0 to 3 wait cycles
    initial begin : memory_model
        logic  busy;
        int    waits;
        data_t word;
        busy = 1'b0;
        waits = 0;
        ext_count = 0;
        mem_ack = 1'b0;
        mem_rdat = '0;
        forever begin
            @(negedge clk);
            if (rst) begin
                mem_ack = 1'b0;
                busy = 1'b0;
            end else if (mem_ack) begin
                mem_ack = 1'b0;
            end else if (mem_cyc && mem_stb) begin
                if (!busy) begin
                    busy = 1'b1;
                    waits = draw_bits(2);
                end
                if (waits == 0) begin
                    word = mem_words.exists(mem_adr[31:2]) ? mem_words[mem_adr[31:2]] : '0;
                    if (mem_we) begin
                        for (int b = 0; b < 4; b++) begin
                            if (mem_sel[b]) begin
                                word[b*8 +: 8] = mem_wdat[b*8 +: 8];
                            end
                        end
                        mem_words[mem_adr[31:2]] = word;
                    end
                    mem_rdat = word;
                    last_adr = mem_adr;
                    last_we = mem_we;
                    last_sel = mem_sel;
                    last_dat = mem_wdat;
                    ext_count++;
                    mem_ack = 1'b1;
                    busy = 1'b0;
                end else begin
                    waits--;
                end
            end
        end
    end

    task automatic run_access(input logic is_write, input addr_t vaddr, input sel_t sel,
                              input data_t wdata, input data_t exp_rdata, input logic exp_ext);
        int    ext_before;
        int    errors_before;
        int    waited;
        int    gap;
        logic  got_ack;
        data_t rdata;
        ext_before = ext_count;
        errors_before = errors;
        waited = 0;
        got_ack = 1'b0;
        accesses++;
        cpu_cyc = 1'b1;
        cpu_stb = 1'b1;
        cpu_we = is_write;
        cpu_adr = vaddr;
        cpu_sel = sel;
        cpu_wdat = wdata;
        while (!got_ack && waited < ack_timeout) begin
            @(negedge clk);
            waited++;
            got_ack = cpu_ack;
        end
        if (!got_ack) begin
            $display("no cpu_ack_o within %0d cycles on access %0d", ack_timeout, accesses);
            errors++;
            aborted = 1'b1;
        end else begin
            rdata = cpu_rdat;
            cpu_cyc = 1'b0;
            cpu_stb = 1'b0;
            cpu_we = 1'b0;
            if (!is_write) begin
                compare_word("cpu_dat_o", exp_rdata, rdata);
            end
            compare_word("external cycle count", {31'b0, exp_ext}, ext_count - ext_before);
            if (ext_count - ext_before == 1) begin
                compare_word("mem_adr_o", map_addr(vaddr), last_adr);
                compare_word("mem_we_o", {31'b0, is_write}, {31'b0, last_we});
                if (is_write) begin
                    compare_word("mem_sel_o", {28'b0, sel}, {28'b0, last_sel});
                    compare_word("mem_dat_o", wdata, last_dat);
                end
            end
            // ack is a single cycle pulse
            @(negedge clk);
            assert (!cpu_ack) else begin
                $display("cpu_ack_o stayed high past one cycle on access %0d", accesses);
                errors++;
            end
            gap = draw_bits(2);
            repeat (gap) @(negedge clk);
            assert (!mem_cyc && !mem_stb && !cpu_ack) else begin
                $display("bus cycle or ack seen between accesses after access %0d", accesses);
                errors++;
            end
            if (errors == errors_before) begin
                passed++;
            end
            $display("access %0d: %s %h sel %h: %s", accesses, is_write ? "write" : "read ",
                     vaddr, sel, (errors == errors_before) ? "ok" : "error");
        end
    endtask

    initial begin : main
        int             fd;
        logic [1279:0]  line_buf;
        logic [31:0]    f_op;
        logic [31:0]    f_addr;
        logic [31:0]    f_sel;
        logic [31:0]    f_wdata;
        logic [31:0]    f_rdata;
        logic [31:0]    f_ext;
        errors = 0;
        passed = 0;
        accesses = 0;
        aborted = 1'b0;
        rst = 1'b1;
        cpu_cyc = 1'b0;
        cpu_stb = 1'b0;
        cpu_we = 1'b0;
        cpu_adr = '0;
        cpu_sel = '0;
        cpu_wdat = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        fd = $fopen("verif/dcache_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open verif/dcache_golden.txt");
            errors++;
        end else begin
            // comment lines do not scan and are skipped
            while (!aborted && $fgets(line_buf, fd) != 0) begin
                if ($sscanf(line_buf, "%h %h %h %h %h %h",
                            f_op, f_addr, f_sel, f_wdata, f_rdata, f_ext) == 6) begin
                    run_access(f_op[0], f_addr, f_sel[3:0], f_wdata, f_rdata, f_ext[0]);
                end
            end
            $fclose(fd);
        end
        $display("accesses %0d, passed %0d, failed %0d, mismatches %0d",
                 accesses, passed, accesses - passed, errors);
        if (errors == 0 && accesses > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/dcache_golden.txt
# op vaddr sel wdata rdata ext, all hex
# op 0 read 1 write, rdata checked on reads only, ext 1 when one bus cycle is expected
0 80000010 f 00000000 00000000 1
0 80000010 f 00000000 00000000 0
1 80000010 f 11223344 00000000 1
0 80000010 f 00000000 11223344 0
1 80000010 3 aabbccdd 00000000 1
0 80000010 f 00000000 1122ccdd 0
1 80000010 8 55000000 00000000 1
0 80000010 f 00000000 5522ccdd 0
1 a0000010 f 99999999 00000000 1
0 80000010 f 00000000 5522ccdd 0
0 a0000010 f 00000000 99999999 1
1 00000020 f cafef00d 00000000 1
0 00000020 f 00000000 cafef00d 1
0 00000020 f 00000000 cafef00d 0
0 80000110 f 00000000 00000000 1
0 80000010 f 00000000 99999999 1
1 40000044 5 12345678 00000000 1
0 40000044 f 00000000 00340078 1
0 a0000020 f 00000000 cafef00d 1
1 80000020 2 0000ab00 00000000 1
0 80000020 f 00000000 cafeab0d 0
0 c0000020 f 00000000 00000000 1

// File: project.f
+incdir+include
src/bus_pkg.sv
src/cache_pkg.sv
src/dcache_if.sv
src/cpu_port.sv
src/cache_ctrl.sv
src/bus_master.sv
src/dcache_top.sv
verif/tb_dcache.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_dcache
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASSED$$"

clean:
	rm -rf $(OBJ_DIR)
